// File: design/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // ----------------------------------------------------------
    // sizes
    // ----------------------------------------------------------
    localparam int NUM_REGS     = 32;
    localparam int MEM_WORDS    = 64;
    localparam int MEM_ADDR_W   = $clog2(MEM_WORDS);
    localparam int QUEUE_DEPTH  = 2;
    localparam int QUEUE_PTR_W  = $clog2(QUEUE_DEPTH);

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // holds 0 .. QUEUE_DEPTH
    typedef logic [1:0]  credit_t;

    // ----------------------------------------------------------
    // encodings
    // ----------------------------------------------------------

    // compares give 1 or 0
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or,
        alu_xor, alu_sll, alu_srl, alu_sra,
        alu_slt, alu_sltu, alu_eq, alu_ne,
        alu_lt, alu_ge, alu_ltu, alu_geu
    } alu_op_t;

    typedef enum logic [3:0] {
        kind_alu_reg,
        kind_alu_imm,
        kind_lui,
        kind_auipc,
        kind_load,
        kind_store,
        kind_branch,
        kind_jal,
        kind_jalr
    } op_kind_t;

    // execute unit sequencing
    typedef enum logic [1:0] {
        st_idle,
        st_first_pass,
        st_second_pass,
        st_send
    } exec_state_t;

    // what the memory stage does with an entry
    typedef enum logic [1:0] {
        mk_write_reg,
        mk_load,
        mk_store
    } mem_kind_t;

endpackage

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu import exec_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result
);

    logic lt_s;
    logic lt_u;
    logic equal;

    // shared compare flags
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;
    assign equal = a == b;

    always_comb begin
        result = '0;
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;

            // shift amount from low 5 bits only
            alu_sll:  result = a << b[4:0];
            alu_srl:  result = a >> b[4:0];
            alu_sra:  result = word_t'($signed(a) >>> b[4:0]);

            // set-less-than and branch compares
            alu_slt:  result = word_t'(lt_s);
            alu_sltu: result = word_t'(lt_u);
            alu_lt:   result = word_t'(lt_s);
            alu_ltu:  result = word_t'(lt_u);
            alu_ge:   result = word_t'(!lt_s);
            alu_geu:  result = word_t'(!lt_u);
            alu_eq:   result = word_t'(equal);
            alu_ne:   result = word_t'(!equal);
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/hazard_lock.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_lock import exec_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  reg_addr_t rd,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  logic      lock_set,
    input  reg_addr_t lock_rd,
    input  logic      wb_en,
    input  reg_addr_t wb_rd,
    output logic      issue_blocked
);

    logic [NUM_REGS-1:0] pending;
    logic [NUM_REGS-1:0] set_mask;
    logic [NUM_REGS-1:0] clr_mask;

    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        if (lock_set) set_mask[lock_rd] = 1'b1;
        if (wb_en) clr_mask[wb_rd] = 1'b1;
        // x0 is never locked
        set_mask[0] = 1'b0;
    end

    // set wins over a clear of the same register
    always_ff @(posedge clock) begin
        if (reset) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clr_mask) | set_mask;
        end
    end

    // registered state only, a release this cycle still blocks
    assign issue_blocked = pending[rd] | pending[rs1] | pending[rs2];

    // writeback must retire a write that was locked at issue
    a_wb_was_locked: assert property (@(posedge clock) disable iff (reset)
        wb_en |-> pending[wb_rd]);

endmodule

`default_nettype wire

// File: design/exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

module exec_unit import exec_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      issue_valid,
    output logic      issue_ready,
    input  op_kind_t  kind,
    input  alu_op_t   alu_op,
    input  reg_addr_t rd,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    input  word_t     imm,
    input  word_t     pc,
    input  logic      issue_blocked,
    output logic      lock_set,
    output reg_addr_t lock_rd,
    output logic      res_valid,
    output mem_kind_t res_kind,
    output reg_addr_t res_rd,
    output word_t     res_data,
    output word_t     res_store_data,
    input  logic      credit_return,
    output logic      jump_valid,
    output word_t     jump_pc
);

    exec_state_t state, state_next;
    logic        ready_q;
    credit_t     credits;
    logic        issue_fire;
    logic        send_needed;

    // captured instruction
    op_kind_t    kind_q;
    alu_op_t     alu_op_q;
    reg_addr_t   rd_q;
    word_t       rs1_q, rs2_q, imm_q, pc_q;
    word_t       pass_q;

    word_t       alu_a, alu_b, alu_res;
    alu_op_t     alu_sel;

    function automatic logic writes_reg(input op_kind_t k);
        return (k != kind_store) && (k != kind_branch);
    endfunction

    // ----------------------------------------------------------
    // issue side
    // ----------------------------------------------------------
    assign issue_ready = ready_q & ~issue_blocked;
    assign issue_fire  = issue_valid & issue_ready;
    assign lock_set    = issue_fire & writes_reg(kind) & (rd != '0);
    assign lock_rd     = rd;

    assign send_needed = (kind_q == kind_store) || (writes_reg(kind_q) && rd_q != '0);

    always_comb begin
        state_next = state;
        case (state)
            st_idle:        if (issue_fire) state_next = st_first_pass;
            st_first_pass:  state_next = st_second_pass;
            st_second_pass: state_next = st_send;
            st_send:        if (!send_needed || credits != '0) state_next = st_idle;
            default:        state_next = st_idle;
        endcase
    end

    // ----------------------------------------------------------
    // operand muxing, pass 1 by kind, pass 2 next pc or target
    // ----------------------------------------------------------
    always_comb begin
        alu_a   = pc_q;
        alu_b   = 32'd4;
        alu_sel = alu_add;
        if (state == st_first_pass) begin
            case (kind_q)
                kind_alu_reg, kind_branch: begin
                    alu_a   = rs1_q;
                    alu_b   = rs2_q;
                    alu_sel = alu_op_q;
                end
                kind_alu_imm: begin
                    alu_a   = rs1_q;
                    alu_b   = imm_q;
                    alu_sel = alu_op_q;
                end
                kind_lui: begin
                    alu_a = imm_q;
                    alu_b = '0;
                end
                kind_auipc, kind_jal: begin
                    alu_a = pc_q;
                    alu_b = imm_q;
                end
                // load, store, jalr
                default: begin
                    alu_a = rs1_q;
                    alu_b = imm_q;
                end
            endcase
        end else if (kind_q == kind_branch) begin
            alu_b = imm_q;
        end
    end

    alu i_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_sel),
        .result (alu_res)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= st_idle;
            ready_q    <= 1'b0;
            credits    <= credit_t'(QUEUE_DEPTH);
            jump_valid <= 1'b0;
        end else begin
            state      <= state_next;
            ready_q    <= state_next == st_idle;
            credits    <= credits - credit_t'(res_valid) + credit_t'(credit_return);
            jump_valid <= (state == st_second_pass) &&
                          ((kind_q == kind_branch) ? pass_q[0] :
                           (kind_q == kind_jal || kind_q == kind_jalr));
        end
    end

    always_ff @(posedge clock) begin
        if (issue_fire) begin
            kind_q   <= kind;
            alu_op_q <= alu_op;
            rd_q     <= rd;
            rs1_q    <= rs1_data;
            rs2_q    <= rs2_data;
            imm_q    <= imm;
            pc_q     <= pc;
        end
        if (state == st_first_pass) pass_q <= alu_res;
        if (state == st_second_pass) begin
            case (kind_q)
                kind_branch: jump_pc <= alu_res;
                kind_jalr:   jump_pc <= {pass_q[31:1], 1'b0};
                default:     jump_pc <= pass_q;
            endcase
            // jumps keep the link value as the result
            if (kind_q == kind_jal || kind_q == kind_jalr) pass_q <= alu_res;
        end
    end

    // result channel
    assign res_valid      = (state == st_send) && send_needed && (credits != '0);
    assign res_kind       = (kind_q == kind_store) ? mk_store :
                            (kind_q == kind_load)  ? mk_load  : mk_write_reg;
    assign res_rd         = rd_q;
    assign res_data       = pass_q;
    assign res_store_data = rs2_q;

    a_credit_max: assert property (@(posedge clock) disable iff (reset)
        credits <= credit_t'(QUEUE_DEPTH));

endmodule

`default_nettype wire

// File: design/mem_access.sv
`timescale 1ns/100ps
`default_nettype none

module mem_access import exec_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      res_valid,
    input  mem_kind_t res_kind,
    input  reg_addr_t res_rd,
    input  word_t     res_data,
    input  word_t     res_store_data,
    output logic      credit_return,
    output logic      wb_en,
    output reg_addr_t wb_rd,
    output word_t     wb_data
);

    mem_kind_t              q_kind  [QUEUE_DEPTH];
    reg_addr_t              q_rd    [QUEUE_DEPTH];
    word_t                  q_data  [QUEUE_DEPTH];
    word_t                  q_store [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr, rd_ptr;
    credit_t                count;

    word_t                  ram [MEM_WORDS];
    word_t                  load_q;
    logic                   load_wait;

    logic                   head_valid;
    mem_kind_t              head_kind;
    logic [MEM_ADDR_W-1:0]  head_addr;
    logic                   pop;

    assign head_valid = count != '0;
    assign head_kind  = q_kind[rd_ptr];
    // word address from byte address
    assign head_addr  = q_data[rd_ptr][MEM_ADDR_W+1:2];

    // loads take a second cycle for the ram read
    assign pop = head_valid && (head_kind != mk_load || load_wait);

    assign credit_return = pop;
    assign wb_en         = pop && head_kind != mk_store;
    assign wb_rd         = q_rd[rd_ptr];
    assign wb_data       = (head_kind == mk_load) ? load_q : q_data[rd_ptr];

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            load_wait <= 1'b0;
        end else begin
            if (res_valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + credit_t'(res_valid) - credit_t'(pop);
            if (head_valid && head_kind == mk_load) load_wait <= ~load_wait;
        end
    end

    // queue payload
    always_ff @(posedge clock) begin
        if (res_valid) begin
            q_kind[wr_ptr]  <= res_kind;
            q_rd[wr_ptr]    <= res_rd;
            q_data[wr_ptr]  <= res_data;
            q_store[wr_ptr] <= res_store_data;
        end
        if (head_valid && head_kind == mk_load && !load_wait) load_q <= ram[head_addr];
    end

    // data ram, zeroed on reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) ram[i] <= '0;
        end else if (head_valid && head_kind == mk_store) begin
            ram[head_addr] <= q_store[rd_ptr];
        end
    end

    a_no_push_full: assert property (@(posedge clock) disable iff (reset)
        res_valid |-> count < credit_t'(QUEUE_DEPTH));

endmodule

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file import exec_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t dbg_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    output word_t     dbg_data,
    input  logic      wb_en,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data
);

    word_t regs [NUM_REGS];

    // x0 stays at its reset value of zero
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) regs[i] <= '0;
        end else if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // combinational read ports
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];
    assign dbg_data = regs[dbg_addr];

endmodule

`default_nettype wire

// File: design/exec_top.sv
`timescale 1ns/100ps
`default_nettype none

module exec_top import exec_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      issue_valid,
    output logic      issue_ready,
    input  op_kind_t  kind,
    input  alu_op_t   alu_op,
    input  reg_addr_t rd,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  word_t     imm,
    input  word_t     pc,
    output logic      jump_valid,
    output word_t     jump_pc,
    input  reg_addr_t dbg_addr,
    output word_t     dbg_data
);

    word_t     rs1_data, rs2_data;
    logic      issue_blocked;
    logic      lock_set;
    reg_addr_t lock_rd;

    // exec to memory stage
    logic      res_valid;
    mem_kind_t res_kind;
    reg_addr_t res_rd;
    word_t     res_data, res_store_data;
    logic      credit_return;

    // writeback
    logic      wb_en;
    reg_addr_t wb_rd;
    word_t     wb_data;

    reg_file i_reg_file (
        .clock    (clock),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .dbg_addr (dbg_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dbg_data (dbg_data),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    hazard_lock i_hazard_lock (
        .clock         (clock),
        .reset         (reset),
        .rd            (rd),
        .rs1           (rs1),
        .rs2           (rs2),
        .lock_set      (lock_set),
        .lock_rd       (lock_rd),
        .wb_en         (wb_en),
        .wb_rd         (wb_rd),
        .issue_blocked (issue_blocked)
    );

    exec_unit i_exec_unit (
        .clock          (clock),
        .reset          (reset),
        .issue_valid    (issue_valid),
        .issue_ready    (issue_ready),
        .kind           (kind),
        .alu_op         (alu_op),
        .rd             (rd),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .imm            (imm),
        .pc             (pc),
        .issue_blocked  (issue_blocked),
        .lock_set       (lock_set),
        .lock_rd        (lock_rd),
        .res_valid      (res_valid),
        .res_kind       (res_kind),
        .res_rd         (res_rd),
        .res_data       (res_data),
        .res_store_data (res_store_data),
        .credit_return  (credit_return),
        .jump_valid     (jump_valid),
        .jump_pc        (jump_pc)
    );

    mem_access i_mem_access (
        .clock          (clock),
        .reset          (reset),
        .res_valid      (res_valid),
        .res_kind       (res_kind),
        .res_rd         (res_rd),
        .res_data       (res_data),
        .res_store_data (res_store_data),
        .credit_return  (credit_return),
        .wb_en          (wb_en),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data)
    );

endmodule

`default_nettype wire

// File: testbench/exec_tb.sv
`timescale 1ns/100ps
`default_nettype none

module exec_tb import exec_pkg::*; ();

    // about 150 instructions at up to ~12 cycles each, plus read-back waits
    localparam int MAX_CYCLES = 4000;
    localparam int JUMP_WINDOW = 6;

    logic      clock;
    logic      reset;
    logic      issue_valid;
    logic      issue_ready;
    op_kind_t  kind;
    alu_op_t   alu_op;
    reg_addr_t rd, rs1, rs2;
    word_t     imm, pc;
    logic      jump_valid;
    word_t     jump_pc;
    reg_addr_t dbg_addr;
    word_t     dbg_data;

    // reference model state
    word_t     model_regs [NUM_REGS];
    word_t     model_mem  [MEM_WORDS];

    integer    seed = 32'h022b_a388;
    int        errors = 0;
    int        checks = 0;
    int        cycles = 0;
    string     test_name = "reset";

    exec_top i_exec_top (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .kind        (kind),
        .alu_op      (alu_op),
        .rd          (rd),
        .rs1         (rs1),
        .rs2         (rs2),
        .imm         (imm),
        .pc          (pc),
        .jump_valid  (jump_valid),
        .jump_pc     (jump_pc),
        .dbg_addr    (dbg_addr),
        .dbg_data    (dbg_data)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic word_t ref_alu(input alu_op_t op, input word_t a, input word_t b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        case (op)
            alu_add:           return a + b;
            alu_sub:           return a - b;
            alu_and:           return a & b;
            alu_or:            return a | b;
            alu_xor:           return a ^ b;
            alu_sll:           return a << b[4:0];
            alu_srl:           return a >> b[4:0];
            alu_sra:           return sa >>> b[4:0];
            alu_slt, alu_lt:   return {31'd0, sa < sb};
            alu_sltu, alu_ltu: return {31'd0, a < b};
            alu_ge:            return {31'd0, sa >= sb};
            alu_geu:           return {31'd0, a >= b};
            alu_eq:            return {31'd0, a == b};
            alu_ne:            return {31'd0, a != b};
            default:           return '0;
        endcase
    endfunction

    task automatic update_model(input op_kind_t k, input alu_op_t op, input reg_addr_t d,
                                input reg_addr_t s1, input reg_addr_t s2, input word_t im,
                                input word_t p, output logic taken, output word_t target);
        word_t a;
        word_t b;
        word_t addr;
        word_t res;
        logic  wr;
        a      = model_regs[s1];
        b      = model_regs[s2];
        addr   = a + im;
        res    = '0;
        wr     = 1'b1;
        taken  = 1'b0;
        target = '0;
        case (k)
            kind_alu_reg: res = ref_alu(op, a, b);
            kind_alu_imm: res = ref_alu(op, a, im);
            kind_lui:     res = im;
            kind_auipc:   res = p + im;
            kind_load:    res = model_mem[addr[7:2]];
            kind_store: begin
                wr = 1'b0;
                model_mem[addr[7:2]] = b;
            end
            kind_branch: begin
                wr     = 1'b0;
                res    = ref_alu(op, a, b);
                taken  = res[0];
                target = p + im;
            end
            kind_jal: begin
                res    = p + 32'd4;
                taken  = 1'b1;
                target = p + im;
            end
            default: begin
                res    = p + 32'd4;
                taken  = 1'b1;
                target = addr & ~32'd1;
            end
        endcase
        if (wr && d != '0) model_regs[d] = res;
    endtask

    // ------------------------------------------------------------
    // driving and checking
    // ------------------------------------------------------------
    task automatic drive_issue(input op_kind_t k, input alu_op_t op, input reg_addr_t d,
                               input reg_addr_t s1, input reg_addr_t s2, input word_t im,
                               input word_t p);
        @(negedge clock);
        kind        = k;
        alu_op      = op;
        rd          = d;
        rs1         = s1;
        rs2         = s2;
        imm         = im;
        pc          = p;
        issue_valid = 1'b1;
        #1;
        while (!issue_ready) begin
            @(negedge clock);
            #1;
        end
        // transfer happens on the next rising edge
        @(negedge clock);
        issue_valid = 1'b0;
    endtask

    task automatic run_instr(input op_kind_t k, input alu_op_t op, input reg_addr_t d,
                             input reg_addr_t s1, input reg_addr_t s2, input word_t im,
                             input word_t p, input logic watch);
        logic  taken;
        word_t target;
        word_t seen;
        int    pulses;
        update_model(k, op, d, s1, s2, im, p, taken, target);
        drive_issue(k, op, d, s1, s2, im, p);
        if (watch) begin
            pulses = 0;
            seen   = '0;
            repeat (JUMP_WINDOW) begin
                if (jump_valid) begin
                    pulses++;
                    seen = jump_pc;
                end
                @(negedge clock);
            end
            checks++;
            assert (pulses == (taken ? 1 : 0)) else begin
                errors++;
                $display("ERR %s: jump pulses expected %0d actual %0d",
                         test_name, taken ? 1 : 0, pulses);
            end
            if (taken) begin
                checks++;
                assert (seen == target) else begin
                    errors++;
                    $display("ERR %s: jump_pc expected %h actual %h", test_name, target, seen);
                end
            end
        end
    endtask

    task automatic set_reg(input reg_addr_t r, input word_t value);
        run_instr(kind_lui, alu_add, r, 5'd0, 5'd0, value, 32'h0, 1'b1);
    endtask

    // waits for the register lock to clear, then reads it back
    task automatic check_reg(input reg_addr_t r);
        @(negedge clock);
        rd       = r;
        rs1      = r;
        rs2      = r;
        dbg_addr = r;
        #1;
        while (!issue_ready) begin
            @(negedge clock);
            #1;
        end
        checks++;
        assert (dbg_data == model_regs[r]) else begin
            errors++;
            $display("ERR %s: x%0d expected %h actual %h", test_name, r, model_regs[r], dbg_data);
        end
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic alu_op_sweep();
        alu_op_t op;
        word_t   im;
        word_t   second;
        test_name = "alu_ops";
        for (int i = 0; i < 16; i++) begin
            op = alu_op_t'(i);
            set_reg(5'd1, $random(seed));
            second = $random(seed);
            // equal operands for the eq/ge paths and the slt boundary
            if (op inside {alu_slt, alu_sltu, alu_eq, alu_ge, alu_geu}) second = model_regs[1];
            set_reg(5'd2, second);
            im = $random(seed);
            run_instr(kind_alu_imm, op, 5'd3, 5'd1, 5'd0, im, 32'h0, 1'b1);
            run_instr(kind_alu_reg, op, 5'd4, 5'd1, 5'd2, '0, 32'h0, 1'b1);
            run_instr(kind_alu_reg, op, 5'd0, 5'd1, 5'd2, '0, 32'h0, 1'b1);
            check_reg(5'd3);
            check_reg(5'd4);
            check_reg(5'd0);
        end
    endtask

    task automatic jump_link();
        test_name = "jumps";
        set_reg(5'd5, 32'h0000_1234);
        run_instr(kind_lui, alu_add, 5'd6, 5'd0, 5'd0, 32'hdead_b000, 32'h100, 1'b1);
        run_instr(kind_auipc, alu_add, 5'd7, 5'd0, 5'd0, 32'h0000_0ff0, 32'h104, 1'b1);
        run_instr(kind_jal, alu_add, 5'd8, 5'd0, 5'd0, 32'h0000_0040, 32'h108, 1'b1);
        // odd sum, bit 0 must be cleared
        run_instr(kind_jalr, alu_add, 5'd9, 5'd5, 5'd0, 32'h0000_0013, 32'h200, 1'b1);
        run_instr(kind_jalr, alu_add, 5'd0, 5'd5, 5'd0, 32'hffff_fff1, 32'h300, 1'b1);
        check_reg(5'd6);
        check_reg(5'd7);
        check_reg(5'd8);
        check_reg(5'd9);
        check_reg(5'd0);
    endtask

    task automatic branch_compares();
        word_t a;
        word_t b;
        test_name = "branches";
        for (int p = 0; p < 3; p++) begin
            case (p)
                0: begin
                    a = 32'd77;
                    b = 32'd77;
                end
                1: begin
                    a = 32'hffff_fffd;
                    b = 32'd7;
                end
                default: begin
                    a = 32'd7;
                    b = 32'hffff_fffd;
                end
            endcase
            set_reg(5'd10, a);
            set_reg(5'd11, b);
            for (int j = 0; j < 6; j++) begin
                run_instr(kind_branch, alu_op_t'(10 + j), 5'd0, 5'd10, 5'd11,
                          32'h0000_0080, word_t'(32'h400 + 16 * j), 1'b1);
            end
        end
    endtask

    task automatic load_store_roundtrip();
        test_name = "load_store";
        set_reg(5'd20, 32'h0000_0040);
        for (int i = 0; i < 4; i++) begin
            set_reg(5'd21, $random(seed));
            run_instr(kind_store, alu_add, 5'd0, 5'd20, 5'd21,
                      word_t'(i * 8) - 32'd8, 32'h0, 1'b1);
        end
        for (int i = 0; i < 4; i++) begin
            run_instr(kind_load, alu_add, reg_addr_t'(22 + i), 5'd20, 5'd0,
                      word_t'(i * 8) - 32'd8, 32'h0, 1'b1);
        end
        for (int i = 0; i < 4; i++) check_reg(reg_addr_t'(22 + i));
    endtask

    task automatic dependent_chains();
        test_name = "dependent";
        set_reg(5'd21, $random(seed));
        run_instr(kind_store, alu_add, 5'd0, 5'd20, 5'd21, 32'h20, 32'h0, 1'b0);
        run_instr(kind_load, alu_add, 5'd26, 5'd20, 5'd0, 32'h20, 32'h0, 1'b0);
        // each op reads the previous result
        run_instr(kind_alu_reg, alu_add, 5'd27, 5'd26, 5'd26, '0, 32'h0, 1'b0);
        run_instr(kind_alu_imm, alu_xor, 5'd28, 5'd27, 5'd0, 32'h5a5a_0f0f, 32'h0, 1'b0);
        run_instr(kind_alu_reg, alu_sub, 5'd28, 5'd28, 5'd26, '0, 32'h0, 1'b0);
        run_instr(kind_alu_imm, alu_sll, 5'd28, 5'd28, 5'd0, 32'd3, 32'h0, 1'b0);
        run_instr(kind_alu_reg, alu_sltu, 5'd29, 5'd28, 5'd27, '0, 32'h0, 1'b0);
        check_reg(5'd26);
        check_reg(5'd27);
        check_reg(5'd28);
        check_reg(5'd29);
    endtask

    task automatic credit_burst();
        test_name = "burst";
        for (int i = 0; i < 20; i++) begin
            if (i % 2 == 0) begin
                run_instr(kind_store, alu_add, 5'd0, 5'd20, (i % 4 == 0) ? 5'd21 : 5'd20,
                          word_t'(32'h80 + 2 * i), 32'h0, 1'b0);
            end else begin
                run_instr(kind_alu_imm, alu_add, reg_addr_t'(1 + i / 2), 5'd21, 5'd0,
                          $random(seed), 32'h0, 1'b0);
            end
        end
        for (int r = 1; r <= 10; r++) check_reg(reg_addr_t'(r));
        // read the stored words back
        for (int i = 0; i < 10; i++) begin
            run_instr(kind_load, alu_add, reg_addr_t'(1 + i), 5'd20, 5'd0,
                      word_t'(32'h80 + 4 * i), 32'h0, 1'b0);
        end
        for (int r = 1; r <= 10; r++) check_reg(reg_addr_t'(r));
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        for (int i = 0; i < NUM_REGS; i++) model_regs[i] = '0;
        for (int i = 0; i < MEM_WORDS; i++) model_mem[i] = '0;
        clock       = 1'b0;
        reset       = 1'b1;
        issue_valid = 1'b0;
        kind        = kind_alu_reg;
        alu_op      = alu_add;
        rd          = '0;
        rs1         = '0;
        rs2         = '0;
        imm         = '0;
        pc          = '0;
        dbg_addr    = '0;
        repeat (10) @(negedge clock);
        reset = 1'b0;

        alu_op_sweep();
        jump_link();
        branch_compares();
        load_store_roundtrip();
        dependent_chains();
        credit_burst();

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
design/exec_pkg.sv
design/alu.sv
design/hazard_lock.sv
design/exec_unit.sv
design/mem_access.sv
design/reg_file.sv
design/exec_top.sv
testbench/exec_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module exec_tb -f verilog.f
	@out=$$(./obj_dir/Vexec_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
